// File: logic/seg_defines.svh
`ifndef SEG_DEFINES_SVH
`define SEG_DEFINES_SVH

// Consecutive high samples needed before a press counts
`define SEG_DEBOUNCE_LEN 4

// Clocks per timer tick, kept short for simulation
`define SEG_TICK_CYCLES 8

// Ticks spent showing G before the walker is released
`define SEG_INIT_TICKS 3

// Ticks the full trail stays lit before the restart
`define SEG_FALL_TICKS 1

`endif

// File: logic/seg_pkg.sv
`default_nettype none

package seg_pkg;

    typedef enum logic [1:0] {
        PH_INIT = 2'd0,
        PH_MOVE = 2'd1,
        PH_FALL = 2'd2
    } phase_t;

    typedef enum logic [1:0] {
        HD_RIGHT = 2'd0,
        HD_LEFT  = 2'd1,
        HD_UP    = 2'd2,
        HD_DOWN  = 2'd3
    } heading_t;

    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_t;

    // Active low, bit i drives segment i
    typedef logic [6:0] seg_mask_t;

    // Raw buttons or single-clock press pulses
    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } buttons_t;

endpackage

`default_nettype wire

// File: logic/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "seg_defines.svh"

module button_sync (
    input  logic              clk,
    input  logic              rst,
    input  seg_pkg::buttons_t btn,
    output seg_pkg::buttons_t press
);

    localparam int LEN = `SEG_DEBOUNCE_LEN;

    logic [LEN-1:0] shift_q [4];
    logic [3:0]     level;
    logic [3:0]     level_q;
    logic [3:0]     press_q;

    // One sample history per button
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                shift_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                shift_q[i] <= {shift_q[i][LEN-2:0], btn[i]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            level[i] = &shift_q[i];
        end
    end

    // Rising edge of the debounced level gives a one-clock pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_q <= '0;
            press_q <= '0;
        end else begin
            level_q <= level;
            press_q <= level & ~level_q;
        end
    end

    assign press = press_q;

endmodule

`default_nettype wire

// File: logic/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "seg_defines.svh"

module phase_timer (
    input  logic            clk,
    input  logic            rst,
    input  seg_pkg::phase_t phase,
    input  logic            trail_full,
    output logic            phase_done
);

    import seg_pkg::*;

    localparam int PRE_W     = $clog2(`SEG_TICK_CYCLES + 1);
    localparam int MAX_TICKS = (`SEG_INIT_TICKS > `SEG_FALL_TICKS) ?
                               `SEG_INIT_TICKS : `SEG_FALL_TICKS;
    localparam int CNT_W     = $clog2(MAX_TICKS + 1);

    logic [PRE_W-1:0] pre_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] limit;
    logic             enable;
    logic             tick;

    // Fall timer only starts once every segment is lit
    assign enable = (phase == PH_INIT) || ((phase == PH_FALL) && trail_full);
    assign tick   = (pre_q == PRE_W'(`SEG_TICK_CYCLES - 1));
    assign limit  = (phase == PH_FALL) ? CNT_W'(`SEG_FALL_TICKS) : CNT_W'(`SEG_INIT_TICKS);

    assign phase_done = enable && (cnt_q >= limit);

    // Done also clears, so the next phase starts from zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_q <= '0;
            cnt_q <= '0;
        end else if (!enable || phase_done) begin
            pre_q <= '0;
            cnt_q <= '0;
        end else if (tick) begin
            pre_q <= '0;
            cnt_q <= cnt_q + 1'b1;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/phase_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module phase_fsm (
    input  logic            clk,
    input  logic            rst,
    input  logic            press_down,
    input  logic            phase_done,
    output seg_pkg::phase_t phase,
    output logic            init,
    output logic            move,
    output logic            fall
);

    import seg_pkg::*;

    phase_t state_q;
    phase_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PH_INIT: begin
                if (phase_done) begin
                    state_d = PH_MOVE;
                end
            end
            PH_MOVE: begin
                if (press_down) begin
                    state_d = PH_FALL;
                end
            end
            PH_FALL: begin
                if (phase_done) begin
                    state_d = PH_INIT;
                end
            end
            // Unused code falls back to a restart
            default: state_d = PH_INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= PH_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign phase = state_q;
    assign init  = (state_q == PH_INIT);
    assign move  = (state_q == PH_MOVE);
    assign fall  = (state_q == PH_FALL);

endmodule

`default_nettype wire

// File: logic/segment_walker.sv
`timescale 1ns/1ps
`default_nettype none

module segment_walker (
    input  logic               clk,
    input  logic               rst,
    input  seg_pkg::phase_t    phase,
    input  seg_pkg::buttons_t  press,
    output seg_pkg::seg_mask_t seg,
    output seg_pkg::heading_t  pos,
    output logic               trail_full
);

    import seg_pkg::*;

    typedef struct packed {
        seg_idx_t idx;
        heading_t head;
    } walk_t;

    localparam walk_t START = '{idx: SEG_G, head: HD_LEFT};

    walk_t     cur_q;
    walk_t     nxt;
    seg_mask_t trail_q;
    seg_mask_t trail;

    // Mask with only the given segment lit
    function automatic seg_mask_t seg_bit(input seg_idx_t idx);
        seg_mask_t m;
        m = ~(7'b1 << idx);
        return m;
    endfunction

    // Move table, left checked before right and right before up
    always_comb begin
        nxt = cur_q;
        case (cur_q.idx)
            SEG_A: begin
                if (cur_q.head == HD_LEFT && press.left) begin
                    nxt = '{SEG_F, HD_DOWN};
                end else if (cur_q.head == HD_RIGHT && press.right) begin
                    nxt = '{SEG_B, HD_DOWN};
                end
            end
            SEG_B: begin
                if (cur_q.head == HD_UP && press.left) begin
                    nxt = '{SEG_A, HD_LEFT};
                end else if (cur_q.head == HD_DOWN && press.right) begin
                    nxt = '{SEG_G, HD_LEFT};
                end else if (cur_q.head == HD_DOWN && press.up) begin
                    nxt = '{SEG_C, HD_DOWN};
                end
            end
            SEG_C: begin
                if (cur_q.head == HD_UP && press.left) begin
                    nxt = '{SEG_G, HD_LEFT};
                end else if (cur_q.head == HD_DOWN && press.right) begin
                    nxt = '{SEG_D, HD_DOWN};
                end else if (cur_q.head == HD_UP && press.up) begin
                    nxt = '{SEG_B, HD_UP};
                end
            end
            SEG_D: begin
                if (cur_q.head == HD_RIGHT && press.left) begin
                    nxt = '{SEG_C, HD_UP};
                end else if (cur_q.head == HD_LEFT && press.right) begin
                    nxt = '{SEG_E, HD_UP};
                end
            end
            SEG_E: begin
                if (cur_q.head == HD_DOWN && press.left) begin
                    nxt = '{SEG_D, HD_RIGHT};
                end else if (cur_q.head == HD_UP && press.right) begin
                    nxt = '{SEG_G, HD_RIGHT};
                end else if (cur_q.head == HD_UP && press.up) begin
                    nxt = '{SEG_F, HD_UP};
                end
            end
            SEG_F: begin
                if (cur_q.head == HD_DOWN && press.left) begin
                    nxt = '{SEG_G, HD_RIGHT};
                end else if (cur_q.head == HD_UP && press.right) begin
                    nxt = '{SEG_A, HD_RIGHT};
                end
            end
            SEG_G: begin
                if (press.left) begin
                    nxt = (cur_q.head == HD_RIGHT) ? '{SEG_B, HD_UP} :
                          (cur_q.head == HD_LEFT)  ? '{SEG_E, HD_DOWN} : cur_q;
                end else if (press.right) begin
                    nxt = (cur_q.head == HD_RIGHT) ? '{SEG_C, HD_DOWN} :
                          (cur_q.head == HD_LEFT)  ? '{SEG_F, HD_UP} : cur_q;
                end
            end
            default: nxt = START;
        endcase
    end

    // Trail includes the segment held right now
    assign trail      = trail_q & seg_bit(cur_q.idx);
    assign trail_full = (trail == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_q   <= START;
            trail_q <= '1;
        end else begin
            cur_q   <= (phase == PH_INIT) ? START : nxt;
            trail_q <= (phase == PH_FALL) ? trail : '1;
        end
    end

    always_comb begin
        case (phase)
            PH_FALL: seg = trail;
            PH_MOVE: seg = seg_bit(cur_q.idx);
            default: seg = seg_bit(SEG_G);
        endcase
    end

    assign pos = (phase == PH_INIT) ? HD_LEFT : cur_q.head;

endmodule

`default_nettype wire

// File: logic/seg_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module seg_game_top (
    input  logic               clk,
    input  logic               rst,
    input  seg_pkg::buttons_t  btn,
    output seg_pkg::seg_mask_t seg,
    output seg_pkg::heading_t  pos,
    output logic               init,
    output logic               move,
    output logic               fall
);

    import seg_pkg::*;

    buttons_t press;
    phase_t   phase;
    logic     trail_full;
    logic     phase_done;

    button_sync u_button_sync (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .press (press)
    );

    phase_timer u_phase_timer (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .trail_full (trail_full),
        .phase_done (phase_done)
    );

    phase_fsm u_phase_fsm (
        .clk        (clk),
        .rst        (rst),
        .press_down (press.down),
        .phase_done (phase_done),
        .phase      (phase),
        .init       (init),
        .move       (move),
        .fall       (fall)
    );

    segment_walker u_segment_walker (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .press      (press),
        .seg        (seg),
        .pos        (pos),
        .trail_full (trail_full)
    );

endmodule

`default_nettype wire

// File: tb/seg_properties.sv
`timescale 1ns/1ps
`default_nettype none

module seg_properties (
    input logic            clk,
    input logic            rst,
    input logic            init,
    input logic            move,
    input logic            fall,
    input logic [3:0]      press,
    input seg_pkg::phase_t phase
);

    import seg_pkg::*;

    int assert_errors = 0;

    a_phase_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot({init, move, fall}))
        else begin
            assert_errors++;
            $error("phase flags not one-hot: init=%b move=%b fall=%b", init, move, fall);
        end

    // A press pulse lasts one clock
    a_press_single: assert property (@(posedge clk) disable iff (rst)
        (press & $past(press)) == 4'b0)
        else begin
            assert_errors++;
            $error("press bit high two clocks in a row: %b", press);
        end

    a_no_init_to_fall: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_INIT) |=> (phase != PH_FALL))
        else begin
            assert_errors++;
            $error("phase went from init straight to fall");
        end

endmodule

bind seg_game_top seg_properties u_props (
    .clk   (clk),
    .rst   (rst),
    .init  (init),
    .move  (move),
    .fall  (fall),
    .press (press),
    .phase (phase)
);

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               check,
    input  int                 test_id,
    input  seg_pkg::seg_mask_t exp_seg,
    input  seg_pkg::heading_t  exp_pos,
    input  seg_pkg::phase_t    exp_phase,
    input  seg_pkg::seg_mask_t seg,
    input  seg_pkg::heading_t  pos,
    input  logic               init,
    input  logic               move,
    input  logic               fall,
    output int                 pass_count,
    output int                 fail_count
);

    import seg_pkg::*;

    logic [2:0] exp_flags;

    // Flags in init, move, fall order
    assign exp_flags = {exp_phase == PH_INIT, exp_phase == PH_MOVE, exp_phase == PH_FALL};

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pass_count = 0;
            fail_count = 0;
        end else if (check) begin
            if (seg === exp_seg && pos === exp_pos && {init, move, fall} === exp_flags) begin
                pass_count = pass_count + 1;
                $display("PASS   test %0d: seg=%b pos=%s phase=%s",
                         test_id, seg, pos.name(), exp_phase.name());
            end else begin
                fail_count = fail_count + 1;
                $display("FAILED at time %0t: test %0d got seg=%b pos=%s flags=%b, %s",
                         $time, test_id, seg, pos.name(), {init, move, fall},
                         $sformatf("expected seg=%b pos=%s flags=%b",
                                   exp_seg, exp_pos.name(), exp_flags));
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    import seg_pkg::*;

    typedef struct packed {
        buttons_t   btn;
        logic [4:0] hold;
        seg_mask_t  seg;
        heading_t   pos;
        phase_t     phase;
    } row_t;

    localparam buttons_t BTN_NONE  = 4'b0000;
    localparam buttons_t BTN_RIGHT = 4'b1000;
    localparam buttons_t BTN_LEFT  = 4'b0100;
    localparam buttons_t BTN_UP    = 4'b0010;
    localparam buttons_t BTN_DOWN  = 4'b0001;
    localparam int       RELEASE   = 8;

    logic      clk;
    logic      rst;
    buttons_t  btn;
    seg_mask_t seg;
    heading_t  pos;
    logic      init;
    logic      move;
    logic      fall;
    logic      check;
    int        test_id;
    seg_mask_t exp_seg;
    heading_t  exp_pos;
    phase_t    exp_phase;
    int        pass_count;
    int        fail_count;
    row_t      rows[$];
    int        cycles = 0;
    int        cycle_limit = 0;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clock (.clk(clk), .rst(rst));

    seg_game_top uut (
        .clk  (clk),
        .rst  (rst),
        .btn  (btn),
        .seg  (seg),
        .pos  (pos),
        .init (init),
        .move (move),
        .fall (fall)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .check      (check),
        .test_id    (test_id),
        .exp_seg    (exp_seg),
        .exp_pos    (exp_pos),
        .exp_phase  (exp_phase),
        .seg        (seg),
        .pos        (pos),
        .init       (init),
        .move       (move),
        .fall       (fall),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // Active low pattern with the named segments lit
    function automatic seg_mask_t lit(input string names);
        seg_mask_t m;
        int        idx;
        m = '1;
        for (int i = 0; i < names.len(); i++) begin
            idx = int'(names[i]) - int'("A");
            m = m & ~(seg_mask_t'(1) << idx);
        end
        return m;
    endfunction

    function automatic logic [2:0] phase_flags(input phase_t ph);
        return {ph == PH_INIT, ph == PH_MOVE, ph == PH_FALL};
    endfunction

    task automatic add_row(input buttons_t b, input int hold, input string segs,
                           input heading_t p, input phase_t ph);
        row_t r;
        r.btn = b;
        r.hold = 5'(hold);
        r.seg = lit(segs);
        r.pos = p;
        r.phase = ph;
        rows.push_back(r);
    endtask

    task automatic press_button(input buttons_t b, input int hold);
        btn = b;
        repeat (hold) @(negedge clk);
        btn = BTN_NONE;
        repeat (RELEASE) @(negedge clk);
    endtask

    task automatic wait_phase(input phase_t ph);
        while ({init, move, fall} != phase_flags(ph)) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        row_t r;
        int   errors;
        btn = BTN_NONE;
        check = 1'b0;
        test_id = 0;
        exp_seg = '1;
        exp_pos = HD_LEFT;
        exp_phase = PH_INIT;

        add_row(BTN_NONE,  0, "G",      HD_LEFT,  PH_INIT);
        add_row(BTN_NONE,  0, "G",      HD_LEFT,  PH_MOVE);
        add_row(BTN_RIGHT, 8, "F",      HD_UP,    PH_MOVE);
        // No entry for up at F heading up
        add_row(BTN_UP,    8, "F",      HD_UP,    PH_MOVE);
        add_row(BTN_RIGHT, 8, "A",      HD_RIGHT, PH_MOVE);
        add_row(BTN_RIGHT, 8, "B",      HD_DOWN,  PH_MOVE);
        add_row(BTN_RIGHT, 8, "G",      HD_LEFT,  PH_MOVE);
        // Too short to pass the debounce
        add_row(BTN_LEFT,  2, "G",      HD_LEFT,  PH_MOVE);
        add_row(BTN_LEFT,  8, "E",      HD_DOWN,  PH_MOVE);
        add_row(BTN_LEFT,  8, "D",      HD_RIGHT, PH_MOVE);
        add_row(BTN_LEFT,  8, "C",      HD_UP,    PH_MOVE);
        add_row(BTN_LEFT,  8, "G",      HD_LEFT,  PH_MOVE);
        add_row(BTN_DOWN,  8, "G",      HD_LEFT,  PH_FALL);
        add_row(BTN_LEFT,  8, "GE",     HD_DOWN,  PH_FALL);
        add_row(BTN_LEFT,  8, "GED",    HD_RIGHT, PH_FALL);
        add_row(BTN_LEFT,  8, "GEDC",   HD_UP,    PH_FALL);
        add_row(BTN_UP,    8, "GEDCB",  HD_UP,    PH_FALL);
        add_row(BTN_LEFT,  8, "GEDCBA", HD_LEFT,  PH_FALL);
        // F completes the trail, short hold then restart
        add_row(BTN_LEFT,  8, "G",      HD_LEFT,  PH_INIT);
        add_row(BTN_NONE,  0, "G",      HD_LEFT,  PH_MOVE);
        add_row(BTN_RIGHT, 8, "F",      HD_UP,    PH_MOVE);
        cycle_limit = rows.size() * 40 + 400;

        @(negedge rst);
        @(negedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.hold != 0) begin
                press_button(r.btn, int'(r.hold));
            end
            wait_phase(r.phase);
            test_id = i;
            exp_seg = r.seg;
            exp_pos = r.pos;
            exp_phase = r.phase;
            check = 1'b1;
            @(negedge clk);
            check = 1'b0;
        end

        @(negedge clk);
        errors = fail_count + uut.u_props.assert_errors;
        $display("Summary: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, uut.u_props.assert_errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/seg_pkg.sv
logic/button_sync.sv
logic/phase_timer.sv
logic/phase_fsm.sv
logic/segment_walker.sv
logic/seg_game_top.sv
tb/seg_properties.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the exact pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
